/* dcache_top.f */
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_ctrl.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/dcache_top.sv
testbench/tb_dcache_top.sv

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_i,
    input  dcache_pkg::addr_t   addr_i,
    input  dcache_pkg::strb_t   strb_i,
    input  dcache_pkg::word_t   wdata_i,
    input  logic                hit0_i,
    input  logic                hit1_i,
    input  logic                victim_valid_i,
    input  logic                refill_valid_i,
    output logic                ready_o,
    output logic                resp_valid_o,
    output logic                miss_o,
    output logic                wb_valid_o,
    output dcache_pkg::index_t  rd_index_o,
    output dcache_pkg::addr_t   req_addr_o,
    output dcache_pkg::strb_t   req_strb_o,
    output dcache_pkg::word_t   req_wdata_o,
    output logic                victim_way_o,
    output logic                store_we_o,
    output logic                hit_way_o,
    output logic                refill_we_o
);

    dcache_pkg::ctrl_state_t state_q;
    dcache_pkg::ctrl_state_t state_d;
    dcache_pkg::addr_t       req_addr_q;
    dcache_pkg::strb_t       req_strb_q;
    dcache_pkg::word_t       req_wdata_q;
    dcache_pkg::index_t      req_index;
    logic [`DC_SETS-1:0]     lru_q;
    logic [`DC_SETS-1:0]     dirty_q [2];
    logic                    hit;
    logic                    accept;

    assign req_index    = req_addr_q[`DC_IDX_MSB:`DC_IDX_LSB];
    assign hit          = hit0_i | hit1_i;
    assign accept       = req_i & ready_o;
    assign hit_way_o    = hit1_i;
    // lru bit names the way to replace next
    assign victim_way_o = lru_q[req_index];

    assign rd_index_o   = accept ? addr_i[`DC_IDX_MSB:`DC_IDX_LSB] : req_index;
    assign req_addr_o   = req_addr_q;
    assign req_strb_o   = req_strb_q;
    assign req_wdata_o  = req_wdata_q;

    assign store_we_o   = (state_q == dcache_pkg::LOOKUP) & hit & (|req_strb_q);
    assign wb_valid_o   = miss_o & victim_valid_i & dirty_q[victim_way_o][req_index];

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d      = state_q;
        ready_o      = 1'b1;
        resp_valid_o = 1'b0;
        miss_o       = 1'b0;
        refill_we_o  = 1'b0;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (req_i) begin
                    state_d = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (hit) begin
                    resp_valid_o = 1'b1;
                    if (!req_i) begin
                        state_d = dcache_pkg::IDLE;
                    end
                end else begin
                    ready_o = 1'b0;
                    miss_o  = 1'b1;
                    state_d = dcache_pkg::MISS_WAIT;
                end
            end
            dcache_pkg::MISS_WAIT: begin
                ready_o = 1'b0;
                if (refill_valid_i) begin
                    resp_valid_o = 1'b1;
                    refill_we_o  = 1'b1;
                    state_d      = dcache_pkg::IDLE;
                end
            end
            default: state_d = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q  <= addr_i;
            req_strb_q  <= strb_i;
            req_wdata_q <= wdata_i;
        end
    end

    // replacement and dirty tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_q      <= '0;
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
        end else if (refill_we_o) begin
            lru_q[req_index]                  <= ~lru_q[req_index];
            dirty_q[victim_way_o][req_index] <= |req_strb_q;
        end else if (state_q == dcache_pkg::LOOKUP && hit) begin
            lru_q[req_index] <= hit0_i;
            if (store_we_o) begin
                dirty_q[hit_way_o][req_index] <= 1'b1;
            end
        end
    end

    // memory may only answer an outstanding miss
    refill_in_wait_a: assert property (@(posedge clk) disable iff (!rst_n)
        refill_valid_i |-> state_q == dcache_pkg::MISS_WAIT);

    one_writer_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(store_we_o && refill_we_o));

endmodule

/* rtl/dcache_data_array.sv */
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_data_array (
    input  logic                clk,
    input  logic                rst_n,
    input  dcache_pkg::index_t  rd_index_i,
    input  dcache_pkg::addr_t   req_addr_i,
    input  dcache_pkg::strb_t   req_strb_i,
    input  dcache_pkg::word_t   req_wdata_i,
    input  logic                hit_way_i,
    input  logic                victim_way_i,
    input  logic                store_we_i,
    input  logic                refill_we_i,
    input  dcache_pkg::line_t   refill_line_i,
    output dcache_pkg::word_t   rdata_o,
    output dcache_pkg::line_t   victim_line_o
);

    dcache_pkg::index_t   wr_index;
    dcache_pkg::offset_t  wr_ofs;
    logic [1:0]           way_we;
    dcache_pkg::line_t    fill_line;
    dcache_pkg::word_t    bank_wdata [`DC_WORDS];
    dcache_pkg::strb_t    bank_strb [`DC_WORDS];
    dcache_pkg::word_t    way_word [2][`DC_WORDS];
    dcache_pkg::line_t    way_line [2];
    dcache_pkg::word_t    sel_word;
    logic                 colli_q;
    logic                 colli_way_q;
    dcache_pkg::offset_t  colli_ofs_q;
    dcache_pkg::strb_t    colli_strb_q;
    dcache_pkg::word_t    colli_wdata_q;

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::strb_t strb,
                                                      input dcache_pkg::word_t new_w,
                                                      input dcache_pkg::word_t old_w);
        dcache_pkg::word_t w;
        w = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                w[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return w;
    endfunction

    assign wr_index  = req_addr_i[`DC_IDX_MSB:`DC_IDX_LSB];
    assign wr_ofs    = req_addr_i[`DC_OFS_MSB:`DC_OFS_LSB];
    assign way_we[0] = (store_we_i & ~hit_way_i) | (refill_we_i & ~victim_way_i);
    assign way_we[1] = (store_we_i & hit_way_i) | (refill_we_i & victim_way_i);

    ////////////////////////////////////////////////////////////////////////////
    // per bank write data with store bytes folded into the refill line
    ////////////////////////////////////////////////////////////////////////////
    for (genvar b = 0; b < `DC_WORDS; b++) begin : g_wdata
        assign fill_line[32*b +: 32] = (wr_ofs == dcache_pkg::offset_t'(b)) ?
            merge_bytes(req_strb_i, req_wdata_i, refill_line_i[32*b +: 32]) :
            refill_line_i[32*b +: 32];
        assign bank_wdata[b] = refill_we_i ? fill_line[32*b +: 32] : req_wdata_i;
        assign bank_strb[b]  = refill_we_i ? 4'hf :
            ((wr_ofs == dcache_pkg::offset_t'(b)) ? req_strb_i : 4'h0);
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < `DC_WORDS; b++) begin : g_bank
            dcache_pkg::word_t bank_mem [`DC_SETS];
            dcache_pkg::word_t rd_q;

            always_ff @(posedge clk) begin
                for (int i = 0; i < 4; i++) begin
                    if (way_we[w] && bank_strb[b][i]) begin
                        bank_mem[wr_index][8*i +: 8] <= bank_wdata[b][8*i +: 8];
                    end
                end
                rd_q <= bank_mem[rd_index_i];
            end

            // patch a word that was written while being read
            assign way_word[w][b] = (colli_q && colli_way_q == 1'(w) &&
                                     colli_ofs_q == dcache_pkg::offset_t'(b)) ?
                merge_bytes(colli_strb_q, colli_wdata_q, rd_q) : rd_q;
            assign way_line[w][32*b +: 32] = way_word[w][b];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read-after-write collision
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            colli_q <= 1'b0;
        end else begin
            colli_q <= store_we_i & (wr_index == rd_index_i);
        end
    end

    always_ff @(posedge clk) begin
        if (store_we_i) begin
            colli_way_q   <= hit_way_i;
            colli_ofs_q   <= wr_ofs;
            colli_strb_q  <= req_strb_i;
            colli_wdata_q <= req_wdata_i;
        end
    end

    // loads carry a zero strobe, so the merge is a pass-through
    assign sel_word      = refill_we_i ? refill_line_i[32*wr_ofs +: 32] :
                                         way_word[hit_way_i][wr_ofs];
    assign rdata_o       = merge_bytes(req_strb_i, req_wdata_i, sel_word);
    assign victim_line_o = way_line[victim_way_i];

endmodule

/* rtl/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// geometry of the two-way cache
`define DC_SETS     64
`define DC_WORDS    16

// set index field of the byte address
`define DC_IDX_LSB  6
`define DC_IDX_MSB  11

// word within the line
`define DC_OFS_LSB  2
`define DC_OFS_MSB  5

// tag runs from here up to bit 31
`define DC_TAG_LSB  12

`endif

/* rtl/dcache_pkg.sv */
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    typedef logic [31-`DC_TAG_LSB:0]           tag_t;
    typedef logic [`DC_IDX_MSB-`DC_IDX_LSB:0]  index_t;
    typedef logic [`DC_OFS_MSB-`DC_OFS_LSB:0]  offset_t;
    typedef logic [`DC_WORDS*32-1:0]           line_t;

    // lookup sequencing
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS_WAIT
    } ctrl_state_t;

endpackage

/* rtl/dcache_tag_array.sv */
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_tag_array (
    input  logic                clk,
    input  logic                rst_n,
    input  dcache_pkg::index_t  rd_index_i,
    input  dcache_pkg::addr_t   req_addr_i,
    input  logic                victim_way_i,
    input  logic                refill_we_i,
    output logic                hit0_o,
    output logic                hit1_o,
    output logic                victim_valid_o,
    output dcache_pkg::tag_t    victim_tag_o
);

    dcache_pkg::tag_t    req_tag;
    dcache_pkg::index_t  wr_index;
    dcache_pkg::tag_t    rd_tag_q [2];
    logic                rd_valid_q [2];
    logic [1:0]          way_we;
    logic [1:0]          way_hit;

    assign req_tag  = req_addr_i[31:`DC_TAG_LSB];
    assign wr_index = req_addr_i[`DC_IDX_MSB:`DC_IDX_LSB];
    assign way_we   = {2{refill_we_i}} & (victim_way_i ? 2'b10 : 2'b01);

    for (genvar w = 0; w < 2; w++) begin : g_way
        dcache_pkg::tag_t     tag_mem [`DC_SETS];
        logic [`DC_SETS-1:0]  valid_q;

        always_ff @(posedge clk) begin
            if (way_we[w]) begin
                tag_mem[wr_index] <= req_tag;
            end
            rd_tag_q[w] <= tag_mem[rd_index_i];
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                valid_q       <= '0;
                rd_valid_q[w] <= 1'b0;
            end else begin
                if (way_we[w]) begin
                    valid_q[wr_index] <= 1'b1;
                end
                rd_valid_q[w] <= valid_q[rd_index_i];
            end
        end

        assign way_hit[w] = rd_valid_q[w] & (rd_tag_q[w] == req_tag);
    end

    assign hit0_o         = way_hit[0];
    assign hit1_o         = way_hit[1];
    assign victim_valid_o = victim_way_i ? rd_valid_q[1] : rd_valid_q[0];
    assign victim_tag_o   = victim_way_i ? rd_tag_q[1] : rd_tag_q[0];

    // a line is only ever installed in one way
    single_hit_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(hit0_o && hit1_o));

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_i,
    input  dcache_pkg::addr_t  addr_i,
    input  dcache_pkg::strb_t  strb_i,
    input  dcache_pkg::word_t  wdata_i,
    input  logic               refill_valid_i,
    input  dcache_pkg::line_t  refill_line_i,
    output logic               ready_o,
    output logic               resp_valid_o,
    output dcache_pkg::word_t  rdata_o,
    output logic               miss_o,
    output dcache_pkg::addr_t  refill_addr_o,
    output logic               wb_valid_o,
    output dcache_pkg::addr_t  wb_addr_o,
    output dcache_pkg::line_t  wb_line_o
);

    dcache_pkg::index_t  rd_index;
    dcache_pkg::addr_t   req_addr;
    dcache_pkg::strb_t   req_strb;
    dcache_pkg::word_t   req_wdata;
    dcache_pkg::tag_t    victim_tag;
    logic                victim_way;
    logic                victim_valid;
    logic                store_we;
    logic                refill_we;
    logic                hit_way;
    logic                hit0;
    logic                hit1;

    dcache_ctrl ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_i          (req_i),
        .addr_i         (addr_i),
        .strb_i         (strb_i),
        .wdata_i        (wdata_i),
        .hit0_i         (hit0),
        .hit1_i         (hit1),
        .victim_valid_i (victim_valid),
        .refill_valid_i (refill_valid_i),
        .ready_o        (ready_o),
        .resp_valid_o   (resp_valid_o),
        .miss_o         (miss_o),
        .wb_valid_o     (wb_valid_o),
        .rd_index_o     (rd_index),
        .req_addr_o     (req_addr),
        .req_strb_o     (req_strb),
        .req_wdata_o    (req_wdata),
        .victim_way_o   (victim_way),
        .store_we_o     (store_we),
        .hit_way_o      (hit_way),
        .refill_we_o    (refill_we)
    );

    dcache_tag_array tag_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_index_i     (rd_index),
        .req_addr_i     (req_addr),
        .victim_way_i   (victim_way),
        .refill_we_i    (refill_we),
        .hit0_o         (hit0),
        .hit1_o         (hit1),
        .victim_valid_o (victim_valid),
        .victim_tag_o   (victim_tag)
    );

    dcache_data_array data_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_index_i     (rd_index),
        .req_addr_i     (req_addr),
        .req_strb_i     (req_strb),
        .req_wdata_i    (req_wdata),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .store_we_i     (store_we),
        .refill_we_i    (refill_we),
        .refill_line_i  (refill_line_i),
        .rdata_o        (rdata_o),
        .victim_line_o  (wb_line_o)
    );

    // line addresses with the offset bits cleared
    assign refill_addr_o = {req_addr[31:`DC_IDX_LSB], {`DC_IDX_LSB{1'b0}}};
    assign wb_addr_o     = {victim_tag, req_addr[`DC_IDX_MSB:`DC_IDX_LSB],
                            {`DC_IDX_LSB{1'b0}}};

endmodule

/* run.sh */
#!/bin/sh
# build with Verilator, run, and fail if the log holds a fail line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_dcache_top -f dcache_top.f > sim.log 2>&1 &&
    ./obj_dir/Vtb_dcache_top >> sim.log 2>&1 ||
    echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

/* testbench/tb_dcache_top.sv */
`timescale 1ns/1ns
`include "dcache_macros.svh"

module tb_dcache_top;

    localparam int TIMEOUT = 50;

    logic                clk;
    logic                rst_n;
    logic                req_i;
    dcache_pkg::addr_t   addr_i;
    dcache_pkg::strb_t   strb_i;
    dcache_pkg::word_t   wdata_i;
    logic                refill_valid_i;
    dcache_pkg::line_t   refill_line_i;
    logic                ready_o;
    logic                resp_valid_o;
    dcache_pkg::word_t   rdata_o;
    logic                miss_o;
    dcache_pkg::addr_t   refill_addr_o;
    logic                wb_valid_o;
    dcache_pkg::addr_t   wb_addr_o;
    dcache_pkg::line_t   wb_line_o;

    // backing memory, and lines the cache holds modified
    dcache_pkg::line_t   mem_lines [dcache_pkg::addr_t];
    dcache_pkg::line_t   dirty_lines [dcache_pkg::addr_t];
    int                  data_errors = 0;
    int                  flow_errors = 0;
    logic                last_wb;
    dcache_pkg::addr_t   last_wb_addr;

    dcache_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic dcache_pkg::addr_t line_of(input dcache_pkg::addr_t addr);
        return {addr[31:`DC_IDX_LSB], {`DC_IDX_LSB{1'b0}}};
    endfunction

    function automatic dcache_pkg::word_t apply_strobes(input dcache_pkg::word_t old_w,
                                                        input dcache_pkg::strb_t strb,
                                                        input dcache_pkg::word_t new_w);
        dcache_pkg::word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic dcache_pkg::line_t random_line();
        dcache_pkg::line_t l;
        for (int i = 0; i < `DC_WORDS; i++) begin
            l[32*i +: 32] = $urandom();
        end
        return l;
    endfunction

    function automatic dcache_pkg::line_t model_line(input dcache_pkg::addr_t line_addr);
        if (dirty_lines.exists(line_addr)) begin
            return dirty_lines[line_addr];
        end
        return mem_lines[line_addr];
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            data_errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // compare the returned word, then apply any store to the model
    task automatic check_result(input dcache_pkg::addr_t addr, input dcache_pkg::strb_t strb,
                                input dcache_pkg::word_t wdata);
        dcache_pkg::line_t    line;
        dcache_pkg::offset_t  ofs;
        dcache_pkg::word_t    exp;
        line = model_line(line_of(addr));
        ofs  = addr[`DC_OFS_MSB:`DC_OFS_LSB];
        exp  = apply_strobes(line[32*ofs +: 32], strb, wdata);
        assert (rdata_o === exp) else begin
            data_errors++;
            $display("error rdata_o: got %h, expected %h at address %h", rdata_o, exp, addr);
        end
        if (strb != '0) begin
            line[32*ofs +: 32] = exp;
            dirty_lines[line_of(addr)] = line;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!ready_o && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        assert (ready_o) else begin
            flow_errors++;
            $display("request was not accepted, ready_o stayed low");
        end
    endtask

    task automatic access(input dcache_pkg::addr_t addr, input dcache_pkg::strb_t strb,
                          input dcache_pkg::word_t wdata, input logic exp_miss);
        int   n;
        logic saw_miss;
        n        = 0;
        saw_miss = 1'b0;
        last_wb  = 1'b0;
        req_i    = 1'b1;
        addr_i   = addr;
        strb_i   = strb;
        wdata_i  = wdata;
        wait_ready();
        @(posedge clk);
        #1;
        req_i = 1'b0;
        @(negedge clk);
        while (!resp_valid_o && n < TIMEOUT) begin
            if (miss_o) begin
                saw_miss     = 1'b1;
                last_wb      = wb_valid_o;
                last_wb_addr = wb_addr_o;
                assert (refill_addr_o === line_of(addr)) else begin
                    data_errors++;
                    $display("error refill_addr_o: got %h, expected %h",
                             refill_addr_o, line_of(addr));
                end
            end
            n++;
            @(negedge clk);
        end
        // a miss flagged in the response cycle counts too
        if (miss_o) begin
            saw_miss = 1'b1;
        end
        assert (resp_valid_o) else begin
            flow_errors++;
            $display("no response for address %h before the timeout", addr);
        end
        check_bit("miss_o", saw_miss, exp_miss);
        if (!exp_miss) begin
            assert (n == 0) else begin
                flow_errors++;
                $display("hit on address %h answered %0d cycles late", addr, n);
            end
        end
        if (resp_valid_o) begin
            check_result(addr, strb, wdata);
        end
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic reset_and_first_miss();
        @(negedge clk);
        check_bit("ready_o", ready_o, 1'b1);
        check_bit("miss_o", miss_o, 1'b0);
        check_bit("resp_valid_o", resp_valid_o, 1'b0);
        @(posedge clk);
        #1;
        access(32'h0000_1040, 4'h0, '0, 1'b1);
        check_bit("wb_valid_o", last_wb, 1'b0);
    endtask

    task automatic load_hit();
        access(32'h0000_1048, 4'h0, '0, 1'b0);
    endtask

    task automatic store_miss_and_evict();
        access(32'h0000_2084, 4'b0110, 32'hdead_beef, 1'b1);
        access(32'h0000_2084, 4'h0, '0, 1'b0);
        // fill the other way, then push the stored line out
        access(32'h0000_3080, 4'h0, '0, 1'b1);
        check_bit("wb_valid_o", last_wb, 1'b0);
        access(32'h0000_4080, 4'h0, '0, 1'b1);
        check_bit("wb_valid_o", last_wb, 1'b1);
        assert (last_wb_addr === 32'h0000_2080) else begin
            data_errors++;
            $display("error wb_addr_o: got %h, expected %h", last_wb_addr, 32'h0000_2080);
        end
    endtask

    task automatic store_load_forwarding();
        req_i   = 1'b1;
        addr_i  = 32'h0000_104c;
        strb_i  = 4'b1001;
        wdata_i = 32'h1122_3344;
        wait_ready();
        @(posedge clk);
        #1;
        // load of the same word queued right behind the store
        strb_i  = 4'h0;
        wdata_i = '0;
        @(negedge clk);
        check_bit("resp_valid_o", resp_valid_o, 1'b1);
        check_bit("miss_o", miss_o, 1'b0);
        check_bit("ready_o", ready_o, 1'b1);
        check_result(32'h0000_104c, 4'b1001, 32'h1122_3344);
        @(posedge clk);
        #1;
        req_i = 1'b0;
        @(negedge clk);
        check_bit("resp_valid_o", resp_valid_o, 1'b1);
        check_bit("miss_o", miss_o, 1'b0);
        check_result(32'h0000_104c, 4'h0, '0);
        @(posedge clk);
        #1;
    endtask

    task automatic lru_replacement();
        access(32'h0000_50c0, 4'h0, '0, 1'b1);
        access(32'h0000_60c4, 4'h0, '0, 1'b1);
        access(32'h0000_50c8, 4'h0, '0, 1'b0);
        access(32'h0000_70cc, 4'h0, '0, 1'b1);
        check_bit("wb_valid_o", last_wb, 1'b0);
        access(32'h0000_50c0, 4'h0, '0, 1'b0);
        access(32'h0000_60c4, 4'h0, '0, 1'b1);
    endtask

    // memory side answering each miss and taking writebacks
    initial begin : memory_model
        dcache_pkg::addr_t  line_addr;
        int                 wait_cycles;
        void'($urandom(32'hb708));
        refill_valid_i = 1'b0;
        refill_line_i  = '0;
        forever begin
            @(negedge clk);
            if (rst_n && miss_o) begin
                if (wb_valid_o) begin
                    assert (dirty_lines.exists(wb_addr_o)) else begin
                        flow_errors++;
                        $display("writeback of line %h, which should be clean", wb_addr_o);
                    end
                    if (dirty_lines.exists(wb_addr_o)) begin
                        assert (wb_line_o === dirty_lines[wb_addr_o]) else begin
                            data_errors++;
                            $display("error wb_line_o: got %h, expected %h",
                                     wb_line_o, dirty_lines[wb_addr_o]);
                        end
                        dirty_lines.delete(wb_addr_o);
                    end
                    mem_lines[wb_addr_o] = wb_line_o;
                end
                line_addr = refill_addr_o;
                if (!mem_lines.exists(line_addr)) begin
                    mem_lines[line_addr] = random_line();
                end
                wait_cycles = $urandom_range(4, 1);
                repeat (wait_cycles) @(posedge clk);
                #1;
                refill_valid_i = 1'b1;
                refill_line_i  = mem_lines[line_addr];
                @(posedge clk);
                #1;
                refill_valid_i = 1'b0;
            end
        end
    end

    initial begin
        rst_n   = 1'b0;
        req_i   = 1'b0;
        addr_i  = '0;
        strb_i  = '0;
        wdata_i = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_and_first_miss();
        load_hit();
        store_miss_and_evict();
        store_load_forwarding();
        lru_replacement();
        $display("data errors: %0d, protocol errors: %0d", data_errors, flow_errors);
        if (data_errors + flow_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
